// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_hci_ecc_bank
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ecc_pkg.sv
// hsiao secded 39/32 codeword, syndrome and parity mask definitions
`default_nettype none

package ecc_pkg;

  // codeword is check bits over data
  localparam int unsigned CW_BITS = hci_pkg::ECC_BITS + $bits(hci_pkg::data_t);

  typedef logic [hci_pkg::ECC_BITS-1:0] check_t;
  typedef logic [hci_pkg::ECC_BITS-1:0] syndrome_t;

  // bit 0 single corrected, bit 1 double detected
  typedef logic [1:0] err_t;

  typedef struct packed {
    check_t         check;
    hci_pkg::data_t data;
  } codeword_fields_t;

  // same 39 bits seen raw or split into fields
  typedef union packed {
    logic [CW_BITS-1:0] raw;
    codeword_fields_t   fields;
  } codeword_u;

  // row i selects the data bits feeding check bit i, plus check bit i itself
  // data columns are distinct weight-3 vectors, check columns are unit vectors
  localparam logic [hci_pkg::ECC_BITS-1:0][CW_BITS-1:0] H_MASK = {
    39'h40_FFF0_0000,
    39'h20_C00F_FC00,
    39'h10_3C0F_03F0,
    39'h08_2388_E38E,
    39'h04_1264_9A6D,
    39'h02_8952_555B,
    39'h01_44B1_2CB7
  };

endpackage

`default_nettype wire

// File: hci_ecc_bank.sv
// ecc-protected memory bank, decode stage in front of a plain tcdm bank
`timescale 1ns/100ps
`default_nettype none

module hci_ecc_bank (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // protected core port
  input  logic               req_i,
  output logic               gnt_o,
  input  hci_pkg::addr_t     add_i,
  input  logic               wen_i,
  input  hci_pkg::be_t       be_i,
  input  hci_pkg::data_t     data_i,
  input  hci_pkg::ecc_user_t user_i,
  output logic               r_valid_o,
  output hci_pkg::data_t     r_data_o,
  output hci_pkg::ecc_user_t r_user_o,
  // decode status, valid on accepted writes
  output ecc_pkg::syndrome_t syndrome_o,
  output ecc_pkg::err_t      err_o,
  // error log
  output logic [7:0]         corr_cnt_o,
  output logic [7:0]         uncorr_cnt_o,
  output hci_pkg::addr_t     last_err_addr_o,
  output ecc_pkg::syndrome_t last_syndrome_o
);

  // plain bus between ecc stage and bank
  logic           bank_req;
  logic           bank_gnt;
  hci_pkg::addr_t bank_add;
  logic           bank_wen;
  hci_pkg::be_t   bank_be;
  hci_pkg::data_t bank_data;
  hci_pkg::user_t bank_user;
  logic           bank_r_valid;
  hci_pkg::data_t bank_r_data;
  hci_pkg::user_t bank_r_user;

  hci_ecc_dec i_ecc_dec (
    .req_i      ( req_i        ),
    .gnt_o      ( gnt_o        ),
    .add_i      ( add_i        ),
    .wen_i      ( wen_i        ),
    .be_i       ( be_i         ),
    .data_i     ( data_i       ),
    .user_i     ( user_i       ),
    .req_o      ( bank_req     ),
    .gnt_i      ( bank_gnt     ),
    .add_o      ( bank_add     ),
    .wen_o      ( bank_wen     ),
    .be_o       ( bank_be      ),
    .data_o     ( bank_data    ),
    .user_o     ( bank_user    ),
    .r_valid_i  ( bank_r_valid ),
    .r_data_i   ( bank_r_data  ),
    .r_user_i   ( bank_r_user  ),
    .r_valid_o  ( r_valid_o    ),
    .r_data_o   ( r_data_o     ),
    .r_user_o   ( r_user_o     ),
    .syndrome_o ( syndrome_o   ),
    .err_o      ( err_o        )
  );

  hci_tcdm_bank i_bank (
    .clk_i     ( clk_i        ),
    .rst_n_i   ( rst_n_i      ),
    .req_i     ( bank_req     ),
    .gnt_o     ( bank_gnt     ),
    .add_i     ( bank_add     ),
    .wen_i     ( bank_wen     ),
    .be_i      ( bank_be      ),
    .data_i    ( bank_data    ),
    .user_i    ( bank_user    ),
    .r_valid_o ( bank_r_valid ),
    .r_data_o  ( bank_r_data  ),
    .r_user_o  ( bank_r_user  )
  );

  // log sees the protected side handshake and the decode result
  hci_ecc_err_log i_err_log (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .req_i           ( req_i           ),
    .gnt_i           ( gnt_o           ),
    .wen_i           ( wen_i           ),
    .add_i           ( add_i           ),
    .syndrome_i      ( syndrome_o      ),
    .err_i           ( err_o           ),
    .corr_cnt_o      ( corr_cnt_o      ),
    .uncorr_cnt_o    ( uncorr_cnt_o    ),
    .last_err_addr_o ( last_err_addr_o ),
    .last_syndrome_o ( last_syndrome_o )
  );

endmodule

`default_nettype wire

// File: hci_ecc_bank_properties.sv
// bound checks on the ecc bank handshake, decode status and error counters
`timescale 1ns/100ps
`default_nettype none

module hci_ecc_bank_properties (
  input logic          clk_i,
  input logic          rst_n_i,
  input logic          req_i,
  input logic          gnt_i,
  input logic          wen_i,
  input logic          r_valid_i,
  input ecc_pkg::err_t err_i,
  input logic [7:0]    corr_cnt_i,
  input logic [7:0]    uncorr_cnt_i
);

  // exactly one response, one cycle after each accepted request
  a_rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i == $past(req_i && gnt_i))
    else $error("r_valid does not follow the accepted request by one cycle");

  // bank never stalls
  a_gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i == req_i)
    else $error("gnt differs from req");

  // single and double at once is not a valid decode
  a_err_encoding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_i != 2'b11)
    else $error("err reports single and double error together");

  // counters only move on an accepted erroneous write
  a_cnt_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (corr_cnt_i == 8'd0 && uncorr_cnt_i == 8'd0
     && !(req_i && gnt_i && !wen_i && err_i != 2'b00))
    |=> (corr_cnt_i == 8'd0 && uncorr_cnt_i == 8'd0))
    else $error("error counters moved without an erroneous write");

endmodule

`default_nettype wire

// File: hci_ecc_dec.sv
// hci ecc stage that strips and checks ecc on requests and re-encodes read data
`timescale 1ns/100ps
`default_nettype none

module hci_ecc_dec (
  // protected request side
  input  logic               req_i,
  output logic               gnt_o,
  input  hci_pkg::addr_t     add_i,
  input  logic               wen_i,
  input  hci_pkg::be_t       be_i,
  input  hci_pkg::data_t     data_i,
  input  hci_pkg::ecc_user_t user_i,
  // plain request side
  output logic               req_o,
  input  logic               gnt_i,
  output hci_pkg::addr_t     add_o,
  output logic               wen_o,
  output hci_pkg::be_t       be_o,
  output hci_pkg::data_t     data_o,
  output hci_pkg::user_t     user_o,
  // plain response side
  input  logic               r_valid_i,
  input  hci_pkg::data_t     r_data_i,
  input  hci_pkg::user_t     r_user_i,
  // protected response side
  output logic               r_valid_o,
  output hci_pkg::data_t     r_data_o,
  output hci_pkg::ecc_user_t r_user_o,
  // decode status of the current request
  output ecc_pkg::syndrome_t syndrome_o,
  output ecc_pkg::err_t      err_o
);

  localparam int unsigned UW = $bits(hci_pkg::user_t);

  ecc_pkg::codeword_u req_cw;
  ecc_pkg::codeword_u rsp_cw;

  // handshake and control pass straight through
  assign req_o     = req_i;
  assign gnt_o     = gnt_i;
  assign add_o     = add_i;
  assign wen_o     = wen_i;
  assign be_o      = be_i;
  assign r_valid_o = r_valid_i;

  // check bits live above the plain user bits
  always_comb begin
    req_cw.fields.check = user_i[UW +: hci_pkg::ECC_BITS];
    req_cw.fields.data  = data_i;
  end

  assign user_o = user_i[UW-1:0];

  secded_39_32_dec i_ecc_decode (
    .codeword_i ( req_cw     ),
    .data_o     ( data_o     ),
    .syndrome_o ( syndrome_o ),
    .err_o      ( err_o      )
  );

  secded_39_32_enc i_ecc_encode (
    .data_i     ( r_data_i ),
    .codeword_o ( rsp_cw   )
  );

  // fresh check bits go back on top of r_user
  assign r_data_o = rsp_cw.fields.data;
  assign r_user_o = {rsp_cw.fields.check, r_user_i};

endmodule

`default_nettype wire

// File: hci_ecc_err_log.sv
// ecc error log, counts corrected and uncorrectable writes and keeps the last one
`timescale 1ns/100ps
`default_nettype none

module hci_ecc_err_log (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               gnt_i,
  input  logic               wen_i,
  input  hci_pkg::addr_t     add_i,
  input  ecc_pkg::syndrome_t syndrome_i,
  input  ecc_pkg::err_t      err_i,
  output logic [7:0]         corr_cnt_o,
  output logic [7:0]         uncorr_cnt_o,
  output hci_pkg::addr_t     last_err_addr_o,
  output ecc_pkg::syndrome_t last_syndrome_o
);

  logic wr_accept;

  // only write data is decoded, reads are ignored
  assign wr_accept = req_i & gnt_i & ~wen_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      corr_cnt_o      <= '0;
      uncorr_cnt_o    <= '0;
      last_err_addr_o <= '0;
      last_syndrome_o <= '0;
    end else if (wr_accept) begin
      // counters saturate at 255
      if (err_i[0] && (corr_cnt_o != 8'hff)) begin
        corr_cnt_o <= corr_cnt_o + 8'd1;
      end
      if (err_i[1] && (uncorr_cnt_o != 8'hff)) begin
        uncorr_cnt_o <= uncorr_cnt_o + 8'd1;
      end
      // capture where and what, for either kind
      if (|err_i) begin
        last_err_addr_o <= add_i;
        last_syndrome_o <= syndrome_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hci_pkg.sv
// hci core port field types, plain and ecc-extended
`default_nettype none

`include "hci_settings.svh"

package hci_pkg;

  // number of secded check bits carried in the user field
  localparam int unsigned ECC_BITS = 7;

  // byte address
  typedef logic [`HCI_AW-1:0] addr_t;
  // data width is fixed at 32
  typedef logic [31:0] data_t;
  // one enable per byte lane
  typedef logic [3:0] be_t;
  // plain user bits as seen by the bank
  typedef logic [`HCI_UW-1:0] user_t;
  // user bits on the protected side, check bits on top
  typedef logic [`HCI_UW+ECC_BITS-1:0] ecc_user_t;

endpackage

`default_nettype wire

// File: hci_settings.svh
// hci ecc bank settings, bus widths and bank depth
`ifndef HCI_SETTINGS_SVH
`define HCI_SETTINGS_SVH

// byte address width of the core port
`define HCI_AW 12

// plain user width, the ecc bits sit above these
`define HCI_UW 4

// bank depth in 32-bit words
`define HCI_BANK_WORDS 256

`endif

// File: hci_tcdm_bank.sv
// single-port tcdm bank with byte enables and one-cycle response
`timescale 1ns/100ps
`default_nettype none

`include "hci_settings.svh"

module hci_tcdm_bank (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  output logic           gnt_o,
  input  hci_pkg::addr_t add_i,
  input  logic           wen_i,
  input  hci_pkg::be_t   be_i,
  input  hci_pkg::data_t data_i,
  input  hci_pkg::user_t user_i,
  output logic           r_valid_o,
  output hci_pkg::data_t r_data_o,
  output hci_pkg::user_t r_user_o
);

  localparam int unsigned IDX_W = $clog2(`HCI_BANK_WORDS);

  hci_pkg::data_t data_mem [`HCI_BANK_WORDS];
  hci_pkg::user_t user_mem [`HCI_BANK_WORDS];

  logic [IDX_W-1:0] idx;
  logic             accept;

  // no contention, every request is granted
  assign gnt_o  = req_i;
  assign accept = req_i & gnt_o;

  // word index, byte offset dropped
  assign idx = add_i[2 +: IDX_W];

  // wen high is a read
  always_ff @(posedge clk_i) begin
    if (accept && !wen_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) data_mem[idx][8*b +: 8] <= data_i[8*b +: 8];
      end
      // user goes along with any enabled byte
      if (|be_i) user_mem[idx] <= user_i;
    end
  end

  // read word, write responses carry stale data
  always_ff @(posedge clk_i) begin
    if (accept && wen_i) begin
      r_data_o <= data_mem[idx];
      r_user_o <= user_mem[idx];
    end
  end

  // one response per accepted request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= accept;
    end
  end

endmodule

`default_nettype wire

// File: secded_39_32_dec.sv
// secded 39/32 decoder, corrects single errors and flags double errors
`timescale 1ns/100ps
`default_nettype none

module secded_39_32_dec (
  input  ecc_pkg::codeword_u codeword_i,
  output hci_pkg::data_t     data_o,
  output ecc_pkg::syndrome_t syndrome_o,
  output ecc_pkg::err_t      err_o
);

  localparam int unsigned NB_CHECK = hci_pkg::ECC_BITS;
  localparam int unsigned DW       = $bits(hci_pkg::data_t);

  logic single_err;
  logic double_err;

  // syndrome over the whole codeword, check bit included in its own row
  always_comb begin
    for (int i = 0; i < NB_CHECK; i++) begin
      syndrome_o[i] = ^(codeword_i.raw & ecc_pkg::H_MASK[i]);
    end
  end

  // odd weight means one flipped bit
  assign single_err = ^syndrome_o;
  // nonzero even weight means two flipped bits
  assign double_err = (syndrome_o != '0) && !single_err;

  assign err_o = {double_err, single_err};

  // flip the data bit whose mask column equals the syndrome
  // a flipped check bit matches no data column, data passes untouched
  always_comb begin
    ecc_pkg::syndrome_t column;
    column = '0;
    data_o = codeword_i.fields.data;
    for (int j = 0; j < DW; j++) begin
      // gather column j of the parity matrix
      for (int i = 0; i < NB_CHECK; i++) begin
        column[i] = ecc_pkg::H_MASK[i][j];
      end
      if (single_err && (syndrome_o == column)) begin
        data_o[j] = ~data_o[j];
      end
    end
  end

endmodule

`default_nettype wire

// File: secded_39_32_enc.sv
// secded 39/32 encoder, adds 7 hsiao check bits to a 32-bit word
`timescale 1ns/100ps
`default_nettype none

module secded_39_32_enc (
  input  hci_pkg::data_t    data_i,
  output ecc_pkg::codeword_u codeword_o
);

  localparam int unsigned NB_CHECK = hci_pkg::ECC_BITS;
  localparam int unsigned DW       = $bits(hci_pkg::data_t);

  // each check bit is the parity of the data bits in its mask row
  always_comb begin
    codeword_o.fields.data = data_i;
    for (int i = 0; i < NB_CHECK; i++) begin
      // only the data part of the row matters here
      codeword_o.fields.check[i] = ^(data_i & ecc_pkg::H_MASK[i][DW-1:0]);
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
hci_pkg.sv
ecc_pkg.sv
secded_39_32_enc.sv
secded_39_32_dec.sv
hci_ecc_dec.sv
hci_tcdm_bank.sv
hci_ecc_err_log.sv
hci_ecc_bank.sv
tb_clock_gen.sv
hci_ecc_bank_properties.sv
tb_hci_ecc_bank.sv

// File: tb_clock_gen.sv
// testbench clock and reset source, 100 ns period, reset held 16 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release just after an edge, away from the sampling point
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_hci_ecc_bank.sv
// testbench for the ecc-protected hci bank with directed tests against reference check bits
`timescale 1ns/100ps
`default_nettype none

module tb_hci_ecc_bank;

  // tests take under 200 cycles so the limit leaves a wide margin
  localparam int unsigned MAX_CYCLES = 2000;
  localparam int unsigned UW = $bits(hci_pkg::user_t);
  localparam int unsigned DW = $bits(hci_pkg::data_t);

  logic               clk;
  logic               rst_n;
  logic               req;
  logic               gnt;
  hci_pkg::addr_t     add;
  logic               wen;
  hci_pkg::be_t       be;
  hci_pkg::data_t     wdata;
  hci_pkg::ecc_user_t wuser;
  logic               r_valid;
  hci_pkg::data_t     r_data;
  hci_pkg::ecc_user_t r_user;
  ecc_pkg::syndrome_t syndrome;
  ecc_pkg::err_t      err;
  logic [7:0]         corr_cnt;
  logic [7:0]         uncorr_cnt;
  hci_pkg::addr_t     last_err_addr;
  ecc_pkg::syndrome_t last_syndrome;

  int unsigned n_pass = 0;
  int unsigned n_fail = 0;
  int unsigned cycles = 0;
  bit          finished = 1'b0;

  tb_clock_gen i_clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  hci_ecc_bank hci_ecc_bank_i (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .req_i           ( req           ),
    .gnt_o           ( gnt           ),
    .add_i           ( add           ),
    .wen_i           ( wen           ),
    .be_i            ( be            ),
    .data_i          ( wdata         ),
    .user_i          ( wuser         ),
    .r_valid_o       ( r_valid       ),
    .r_data_o        ( r_data        ),
    .r_user_o        ( r_user        ),
    .syndrome_o      ( syndrome      ),
    .err_o           ( err           ),
    .corr_cnt_o      ( corr_cnt      ),
    .uncorr_cnt_o    ( uncorr_cnt    ),
    .last_err_addr_o ( last_err_addr ),
    .last_syndrome_o ( last_syndrome )
  );

  bind hci_ecc_bank hci_ecc_bank_properties i_props (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_i        ( req_i        ),
    .gnt_i        ( gnt_o        ),
    .wen_i        ( wen_i        ),
    .r_valid_i    ( r_valid_o    ),
    .err_i        ( err_o        ),
    .corr_cnt_i   ( corr_cnt_o   ),
    .uncorr_cnt_i ( uncorr_cnt_o )
  );

  // reference check bits as the parity of the data part of each mask row
  function automatic ecc_pkg::check_t ref_check(hci_pkg::data_t d);
    ecc_pkg::check_t c;
    for (int i = 0; i < hci_pkg::ECC_BITS; i++) begin
      c[i] = ^(d & ecc_pkg::H_MASK[i][DW-1:0]);
    end
    return c;
  endfunction

  // column j of the parity matrix is the syndrome of a flip at codeword bit j
  function automatic ecc_pkg::syndrome_t mask_column(int unsigned j);
    ecc_pkg::syndrome_t col;
    for (int i = 0; i < hci_pkg::ECC_BITS; i++) begin
      col[i] = ecc_pkg::H_MASK[i][j];
    end
    return col;
  endfunction

  function automatic hci_pkg::ecc_user_t encode_user(hci_pkg::data_t d, hci_pkg::user_t u);
    return {ref_check(d), u};
  endfunction

  task automatic check_data(hci_pkg::data_t got, hci_pkg::data_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s data %h, expected %h", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_user(hci_pkg::ecc_user_t got, hci_pkg::ecc_user_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s user %h, expected %h", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_err(ecc_pkg::err_t got, ecc_pkg::err_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s err %b, expected %b", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_syndrome(ecc_pkg::syndrome_t got, ecc_pkg::syndrome_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s syndrome %b, expected %b", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_count(logic [7:0] got, logic [7:0] exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_addr(hci_pkg::addr_t got, hci_pkg::addr_t exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s address %h, expected %h", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic report_test(string name, int unsigned fail0);
    $display("%s done, %0d failed checks", name, n_fail - fail0);
  endtask

  // response is due right after the accepting edge
  task automatic wait_response();
    int unsigned n;
    n = 0;
    while (r_valid !== 1'b1) begin
      if (n == 4) begin
        $display("error at %0t ns: no response within 4 cycles of a request", $time);
        n_fail++;
        return;
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // decode status sampled mid-cycle while the request is held
  task automatic do_write(hci_pkg::addr_t a, hci_pkg::be_t b, hci_pkg::data_t d,
                          hci_pkg::ecc_user_t u, output ecc_pkg::err_t e,
                          output ecc_pkg::syndrome_t s);
    @(posedge clk);
    #1;
    req = 1'b1;
    wen = 1'b0;
    add = a;
    be = b;
    wdata = d;
    wuser = u;
    @(negedge clk);
    e = err;
    s = syndrome;
    @(posedge clk);
    #1;
    req = 1'b0;
    wen = 1'b1;
    be = '0;
    wait_response();
  endtask

  task automatic do_read(hci_pkg::addr_t a, output hci_pkg::data_t d,
                         output hci_pkg::ecc_user_t u);
    @(posedge clk);
    #1;
    req = 1'b1;
    wen = 1'b1;
    add = a;
    @(posedge clk);
    #1;
    req = 1'b0;
    wait_response();
    d = r_data;
    u = r_user;
  endtask

  task automatic test_reset_state();
    int unsigned fail0;
    fail0 = n_fail;
    repeat (4) @(posedge clk);
    #2;
    check_flag(r_valid, 1'b0, "r_valid in reset");
    check_count(corr_cnt, 8'd0, "corrected in reset");
    check_count(uncorr_cnt, 8'd0, "uncorrectable in reset");
    check_addr(last_err_addr, '0, "last address in reset");
    check_syndrome(last_syndrome, '0, "last syndrome in reset");
    @(posedge rst_n);
    @(posedge clk);
    #1;
    check_flag(r_valid, 1'b0, "r_valid after reset");
    check_count(corr_cnt, 8'd0, "corrected after reset");
    check_count(uncorr_cnt, 8'd0, "uncorrectable after reset");
    check_addr(last_err_addr, '0, "last address after reset");
    check_syndrome(last_syndrome, '0, "last syndrome after reset");
    report_test("reset state", fail0);
  endtask

  task automatic test_clean_round_trip();
    hci_pkg::data_t     d [16];
    hci_pkg::user_t     u [16];
    hci_pkg::data_t     got_d;
    hci_pkg::ecc_user_t got_u;
    ecc_pkg::err_t      e;
    ecc_pkg::syndrome_t s;
    int unsigned        fail0;
    fail0 = n_fail;
    for (int i = 0; i < 16; i++) begin
      d[i] = $urandom();
      u[i] = hci_pkg::user_t'($urandom());
      do_write(hci_pkg::addr_t'(4 * i), 4'hf, d[i], encode_user(d[i], u[i]), e, s);
      check_err(e, 2'b00, "clean write");
    end
    for (int i = 0; i < 16; i++) begin
      do_read(hci_pkg::addr_t'(4 * i), got_d, got_u);
      check_data(got_d, d[i], "clean read");
      check_user(got_u, encode_user(d[i], u[i]), "clean read");
    end
    check_count(corr_cnt, 8'd0, "corrected after clean traffic");
    check_count(uncorr_cnt, 8'd0, "uncorrectable after clean traffic");
    report_test("clean round trip", fail0);
  endtask

  task automatic test_data_flip();
    hci_pkg::data_t     d;
    hci_pkg::user_t     u;
    hci_pkg::data_t     got_d;
    hci_pkg::ecc_user_t got_u;
    ecc_pkg::err_t      e;
    ecc_pkg::syndrome_t s;
    logic [7:0]         cnt0;
    int unsigned        bitpos;
    int unsigned        fail0;
    fail0 = n_fail;
    d = $urandom();
    u = hci_pkg::user_t'($urandom());
    bitpos = $urandom_range(DW - 1, 0);
    cnt0 = corr_cnt;
    do_write(12'h100, 4'hf, d ^ (32'h1 << bitpos), encode_user(d, u), e, s);
    check_err(e, 2'b01, "data flip write");
    check_syndrome(s, mask_column(bitpos), "data flip write");
    check_count(corr_cnt, cnt0 + 8'd1, "corrected after data flip");
    do_read(12'h100, got_d, got_u);
    check_data(got_d, d, "data flip read");
    check_user(got_u, encode_user(d, u), "data flip read");
    report_test("single data bit flip", fail0);
  endtask

  task automatic test_check_flip();
    hci_pkg::data_t     d;
    hci_pkg::user_t     u;
    hci_pkg::ecc_user_t wu;
    hci_pkg::data_t     got_d;
    hci_pkg::ecc_user_t got_u;
    ecc_pkg::err_t      e;
    ecc_pkg::syndrome_t s;
    logic [7:0]         cnt0;
    int unsigned        k;
    int unsigned        fail0;
    fail0 = n_fail;
    d = $urandom();
    u = hci_pkg::user_t'($urandom());
    k = $urandom_range(hci_pkg::ECC_BITS - 1, 0);
    wu = encode_user(d, u) ^ (hci_pkg::ecc_user_t'(1) << (UW + k));
    cnt0 = corr_cnt;
    do_write(12'h104, 4'hf, d, wu, e, s);
    check_err(e, 2'b01, "check flip write");
    // only the flipped check bit shows in the syndrome
    check_syndrome(s, ecc_pkg::syndrome_t'(1) << k, "check flip write");
    check_count(corr_cnt, cnt0 + 8'd1, "corrected after check flip");
    check_syndrome(last_syndrome, ecc_pkg::syndrome_t'(1) << k,
                   "last syndrome after check flip");
    do_read(12'h104, got_d, got_u);
    check_data(got_d, d, "check flip read");
    report_test("single check bit flip", fail0);
  endtask

  task automatic test_double_flip();
    hci_pkg::data_t     d;
    hci_pkg::user_t     u;
    ecc_pkg::err_t      e;
    ecc_pkg::syndrome_t s;
    logic [7:0]         cnt0;
    logic [7:0]         corr0;
    int unsigned        b1;
    int unsigned        b2;
    int unsigned        fail0;
    fail0 = n_fail;
    d = $urandom();
    u = hci_pkg::user_t'($urandom());
    b1 = $urandom_range(DW - 1, 0);
    b2 = (b1 + 1 + $urandom_range(DW - 2, 0)) % DW;
    cnt0 = uncorr_cnt;
    corr0 = corr_cnt;
    do_write(12'h2a8, 4'hf, d ^ (32'h1 << b1) ^ (32'h1 << b2), encode_user(d, u), e, s);
    check_err(e, 2'b10, "double flip write");
    check_syndrome(s, mask_column(b1) ^ mask_column(b2), "double flip write");
    check_count(uncorr_cnt, cnt0 + 8'd1, "uncorrectable after double flip");
    check_count(corr_cnt, corr0, "corrected after double flip");
    check_addr(last_err_addr, 12'h2a8, "last address after double flip");
    report_test("double bit flip", fail0);
  endtask

  task automatic test_byte_enables();
    hci_pkg::data_t     d0;
    hci_pkg::data_t     d1;
    hci_pkg::data_t     merged;
    hci_pkg::user_t     u0;
    hci_pkg::user_t     u1;
    hci_pkg::data_t     got_d;
    hci_pkg::ecc_user_t got_u;
    ecc_pkg::err_t      e;
    ecc_pkg::syndrome_t s;
    int unsigned        fail0;
    fail0 = n_fail;
    d0 = $urandom();
    d1 = $urandom();
    u0 = hci_pkg::user_t'($urandom());
    u1 = hci_pkg::user_t'($urandom());
    do_write(12'h200, 4'hf, d0, encode_user(d0, u0), e, s);
    check_err(e, 2'b00, "full write");
    // lanes 0 and 2 come from the new word and user follows the partial write
    do_write(12'h200, 4'b0101, d1, encode_user(d1, u1), e, s);
    check_err(e, 2'b00, "partial write");
    merged = {d0[31:24], d1[23:16], d0[15:8], d1[7:0]};
    do_read(12'h200, got_d, got_u);
    check_data(got_d, merged, "merged read");
    check_user(got_u, encode_user(merged, u1), "merged read");
    report_test("byte enables", fail0);
  endtask

  initial begin
    req = 1'b0;
    wen = 1'b1;
    add = '0;
    be = '0;
    wdata = '0;
    wuser = '0;
    void'($urandom(32'h6549_d911));
    test_reset_state();
    test_clean_round_trip();
    test_data_flip();
    test_check_flip();
    test_double_flip();
    test_byte_enables();
    finished = 1'b1;
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("error: run did not finish within %0d cycles", MAX_CYCLES);
      finished = 1'b1;
      $display("Simulation failed");
      $finish;
    end
  end

  // run ended before the summary
  final begin
    if (!finished) begin
      $display("Simulation failed");
    end
  end

endmodule

`default_nettype wire
